//--- source/fetch_pkg.sv
package fetch_pkg;

  //////////////////////////////////////////////////////////////////////
  // Basic types
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] addr_t;   // Byte address
  typedef logic [31:0] instr_t;  // Instruction word, also a memory data word
  typedef logic [15:0] half_t;   // One halfword, holds a compressed instruction

  //////////////////////////////////////////////////////////////////////
  // Instruction memory port
  //////////////////////////////////////////////////////////////////////

  // Request side, driven by the prefetch buffer
  typedef struct packed {
    logic  req;   // Held high until gnt
    addr_t addr;  // Word address, low two bits always zero
  } instr_req_t;

  // Response side, driven by memory
  // At most one read is outstanding at any time
  typedef struct packed {
    logic   gnt;     // Request accepted this cycle
    logic   rvalid;  // Read data valid, one per grant
    instr_t rdata;
  } instr_rsp_t;

  //////////////////////////////////////////////////////////////////////
  // IF/ID payload
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    instr_t instr;       // Upper half zero for a compressed instruction
    addr_t  pc;          // Always even
    logic   compressed;  // Low bits not 2'b11
  } fetch_out_t;

endpackage

//--- source/fetch_prefetch_buffer.sv
`timescale 1ns/1ps

// Prefetch buffer with a single 16-bit halfword store
// Turns 32-bit memory words into aligned instruction / pc pairs
module fetch_prefetch_buffer (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  req_i,          // Next instruction wanted
  input  logic                  branch_i,       // Redirect pending
  input  fetch_pkg::addr_t      branch_addr_i,  // Even target

  output logic                  valid_o,
  output fetch_pkg::instr_t     rdata_o,
  output fetch_pkg::addr_t      addr_o,
  output logic                  busy_o,         // Any state other than IDLE

  output fetch_pkg::instr_req_t instr_req_o,
  input  fetch_pkg::instr_rsp_t instr_rsp_i
);
  import fetch_pkg::*;

  typedef enum logic [1:0] {IDLE, WAIT_GNT, WAIT_RVALID, WAIT_ABORTED} state_e;

  //////////////////////////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////////////////////////

  state_e state_q, state_d;
  addr_t  pc_q, pc_d;                  // Pc of instruction in flight or last delivered
  logic   last_c_q, last_c_d;          // Last delivered instruction was compressed
  addr_t  word_q, word_d;              // Last fetched word address
  half_t  half_q, half_d;              // Upper halfword of word_q
  logic   half_valid_q, half_valid_d;
  logic   misal_q, misal_d;            // Waiting for the second part of a full instr

  //////////////////////////////////////////////////////////////////////
  // Address selection
  //////////////////////////////////////////////////////////////////////

  addr_t addr_next;  // Sequential successor of pc_q
  addr_t addr_sel;   // Address of the instruction about to be fetched
  addr_t word_sel;   // Word holding addr_sel
  addr_t word_cur;   // Word holding pc_q
  addr_t word_nxt;   // Word after word_cur
  half_t rsp_lo;
  half_t rsp_hi;
  logic  hit;        // Start of addr_sel already sits in half_q

  // Length decode from the two low bits
  function automatic logic is_comp(half_t h);
    return h[1:0] != 2'b11;
  endfunction

  assign addr_next = pc_q + (last_c_q ? 32'd2 : 32'd4);
  assign addr_sel  = branch_i ? branch_addr_i : addr_next;
  assign word_sel  = {addr_sel[31:2], 2'b00};
  assign word_cur  = {pc_q[31:2], 2'b00};
  assign word_nxt  = word_cur + 32'd4;

  assign rsp_lo = instr_rsp_i.rdata[15:0];
  assign rsp_hi = instr_rsp_i.rdata[31:16];

  // A redirect throws the halfword away, so no hit then
  assign hit = !branch_i && half_valid_q && addr_sel[1]
               && (addr_sel[31:2] == word_q[31:2]);

  assign busy_o = (state_q != IDLE);  // No dependency on req, no loop with the IF stage

  //////////////////////////////////////////////////////////////////////
  // Next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    pc_d         = pc_q;
    last_c_d     = last_c_q;
    word_d       = word_q;
    half_d       = half_q;
    half_valid_d = half_valid_q;
    misal_d      = misal_q;

    valid_o      = 1'b0;
    rdata_o      = '0;
    addr_o       = pc_q;
    instr_req_o  = '0;

    unique case (state_q)
      IDLE: begin
        if (req_i) begin
          pc_d = addr_sel;
          if (branch_i) begin
            half_valid_d = 1'b0;  // Buffered half belongs to the old path
          end
          if (hit && is_comp(half_q)) begin
            // Compressed instr already buffered, no memory read
            valid_o  = 1'b1;
            rdata_o  = {16'h0000, half_q};
            addr_o   = addr_sel;
            last_c_d = 1'b1;
          end else begin
            instr_req_o.req  = 1'b1;
            misal_d          = hit;  // Lower half buffered, fetch the upper part
            instr_req_o.addr = hit ? word_sel + 32'd4 : word_sel;
          end
        end
      end

      WAIT_GNT: begin
        // Same address as in the cycle the request started
        instr_req_o.req  = 1'b1;
        instr_req_o.addr = misal_q ? word_nxt : word_cur;
      end

      WAIT_RVALID: begin
        if (branch_i) begin
          // Drop the outstanding word
          half_valid_d = 1'b0;
          misal_d      = 1'b0;
          state_d      = instr_rsp_i.rvalid ? IDLE : WAIT_ABORTED;
        end else if (instr_rsp_i.rvalid) begin
          half_d       = rsp_hi;  // Keep upper half for the next instr
          half_valid_d = 1'b1;
          misal_d      = 1'b0;
          state_d      = IDLE;
          if (misal_q) begin
            // Second part of a word crossing instruction
            word_d   = word_nxt;
            valid_o  = 1'b1;
            rdata_o  = {rsp_lo, half_q};
            last_c_d = 1'b0;
          end else if (!pc_q[1]) begin
            word_d   = word_cur;
            valid_o  = 1'b1;
            rdata_o  = is_comp(rsp_lo) ? {16'h0000, rsp_lo} : instr_rsp_i.rdata;
            last_c_d = is_comp(rsp_lo);
          end else if (is_comp(rsp_hi)) begin
            word_d   = word_cur;  // Compressed in upper half
            valid_o  = 1'b1;
            rdata_o  = {16'h0000, rsp_hi};
            last_c_d = 1'b1;
          end else begin
            // Full instr starts in upper half, read the next word right away
            word_d           = word_cur;
            misal_d          = 1'b1;
            instr_req_o.req  = 1'b1;
            instr_req_o.addr = word_nxt;
          end
        end
      end

      WAIT_ABORTED: begin
        if (instr_rsp_i.rvalid) begin
          state_d = IDLE;  // Stale data ignored
        end
      end

      default: state_d = IDLE;
    endcase

    // Every new or held request waits for its grant
    if (instr_req_o.req) begin
      state_d = instr_rsp_i.gnt ? WAIT_RVALID : WAIT_GNT;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q      <= IDLE;
      pc_q         <= '0;
      last_c_q     <= 1'b0;
      word_q       <= '0;
      half_valid_q <= 1'b0;
      misal_q      <= 1'b0;
    end else begin
      state_q      <= state_d;
      pc_q         <= pc_d;
      last_c_q     <= last_c_d;
      word_q       <= word_d;
      half_valid_q <= half_valid_d;
      misal_q      <= misal_d;
    end
  end

  always_ff @(posedge clk) begin
    half_q <= half_d;  // Qualified by half_valid_q
  end

  // Memory only sees word addresses
  a_req_word_aligned : assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o.req |-> (instr_req_o.addr[1:0] == 2'b00));

  // Request and address stay put until the grant
  a_req_held : assert property (@(posedge clk) disable iff (!rst_n)
    (instr_req_o.req && !instr_rsp_i.gnt)
      |=> (instr_req_o.req && $stable(instr_req_o.addr)));

  a_pc_even : assert property (@(posedge clk) disable iff (!rst_n)
    valid_o |-> !addr_o[0]);

endmodule

//--- source/fetch_if_stage.sv
`timescale 1ns/1ps

// IF stage, branch pending logic, fetch requests and the IF/ID register
module fetch_if_stage #(
  parameter fetch_pkg::addr_t BOOT_ADDR = 32'h0000_0080
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  branch_i,       // One cycle pulse
  input  fetch_pkg::addr_t      branch_addr_i,
  input  logic                  id_ready_i,

  output logic                  id_valid_o,
  output fetch_pkg::fetch_out_t id_data_o,

  output logic                  fetch_req_o,
  output logic                  fetch_branch_o,
  output fetch_pkg::addr_t      fetch_branch_addr_o,
  input  logic                  fetch_valid_i,
  input  fetch_pkg::instr_t     fetch_rdata_i,
  input  fetch_pkg::addr_t      fetch_addr_i,
  input  logic                  busy_i
);
  import fetch_pkg::*;

  logic       boot_q;       // Set one cycle after reset
  logic       pend_q;       // Branch waiting for the buffer
  addr_t      pend_addr_q;
  logic       id_valid_q;
  fetch_out_t id_data_q;
  logic       id_free;      // IF/ID register empty or emptied this cycle
  logic       capture;

  //////////////////////////////////////////////////////////////////////
  // Fetch control
  //////////////////////////////////////////////////////////////////////

  assign id_free = !id_valid_q || id_ready_i;

  // No request in the branch cycle, the old path is dead anyway
  assign fetch_req_o         = boot_q && id_free && !branch_i;
  assign fetch_branch_o      = pend_q;  // Also aborts an outstanding read
  assign fetch_branch_addr_o = pend_addr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      boot_q      <= 1'b0;
      pend_q      <= 1'b0;
      pend_addr_q <= '0;
    end else begin
      boot_q <= 1'b1;
      if (branch_i) begin
        pend_q      <= 1'b1;  // Newest target wins
        pend_addr_q <= branch_addr_i;
      end else if (!boot_q) begin
        pend_q      <= 1'b1;  // First fetch goes to the boot address
        pend_addr_q <= BOOT_ADDR;
      end else if (fetch_req_o && !busy_i) begin
        pend_q      <= 1'b0;  // Buffer took the branch in IDLE
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // IF/ID register
  //////////////////////////////////////////////////////////////////////

  // Buffer only answers a request made while the register was free
  assign capture = fetch_valid_i && !branch_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
    end else if (branch_i) begin
      id_valid_q <= 1'b0;  // Flush
    end else if (fetch_valid_i) begin
      id_valid_q <= 1'b1;
    end else if (id_ready_i) begin
      id_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      id_data_q.instr      <= fetch_rdata_i;
      id_data_q.pc         <= fetch_addr_i;
      id_data_q.compressed <= (fetch_rdata_i[1:0] != 2'b11);
    end
  end

  assign id_valid_o = id_valid_q;
  assign id_data_o  = id_data_q;

  // Holds only if the buffer never delivers into a full register
  a_id_hold : assert property (@(posedge clk) disable iff (!rst_n)
    (id_valid_o && !id_ready_i && !branch_i) |=> (id_valid_o && $stable(id_data_o)));

endmodule

//--- source/fetch_top.sv
`timescale 1ns/1ps

// Fetch front end, IF stage in front of the prefetch buffer
module fetch_top #(
  parameter fetch_pkg::addr_t BOOT_ADDR = 32'h0000_0080
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  branch_i,
  input  fetch_pkg::addr_t      branch_addr_i,
  input  logic                  id_ready_i,

  output logic                  id_valid_o,
  output fetch_pkg::fetch_out_t id_data_o,

  output fetch_pkg::instr_req_t instr_req_o,
  input  fetch_pkg::instr_rsp_t instr_rsp_i
);
  import fetch_pkg::*;

  // IF stage to buffer
  logic   fetch_req;
  logic   fetch_branch;
  addr_t  fetch_branch_addr;

  // Buffer back to IF stage
  logic   fetch_valid;
  instr_t fetch_rdata;
  addr_t  fetch_addr;
  logic   fetch_busy;

  //////////////////////////////////////////////////////////////////////
  // IF stage
  //////////////////////////////////////////////////////////////////////

  fetch_if_stage #(
    .BOOT_ADDR (BOOT_ADDR)
  ) u_if_stage (
    .clk                 (clk),
    .rst_n               (rst_n),
    .branch_i            (branch_i),
    .branch_addr_i       (branch_addr_i),
    .id_ready_i          (id_ready_i),
    .id_valid_o          (id_valid_o),
    .id_data_o           (id_data_o),
    .fetch_req_o         (fetch_req),
    .fetch_branch_o      (fetch_branch),
    .fetch_branch_addr_o (fetch_branch_addr),
    .fetch_valid_i       (fetch_valid),
    .fetch_rdata_i       (fetch_rdata),
    .fetch_addr_i        (fetch_addr),
    .busy_i              (fetch_busy)
  );

  //////////////////////////////////////////////////////////////////////
  // Prefetch buffer, owns the memory port
  //////////////////////////////////////////////////////////////////////

  fetch_prefetch_buffer u_prefetch (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_i         (fetch_req),
    .branch_i      (fetch_branch),
    .branch_addr_i (fetch_branch_addr),
    .valid_o       (fetch_valid),
    .rdata_o       (fetch_rdata),
    .addr_o        (fetch_addr),
    .busy_o        (fetch_busy),
    .instr_req_o   (instr_req_o),
    .instr_rsp_i   (instr_rsp_i)
  );

endmodule

//--- dv/fetch_tb_mem.sv
`timescale 1ns/1ps

// Instruction memory model, one outstanding read, random grant and read latency
module fetch_tb_mem (
  input  logic                  clk,
  input  logic                  rst_n,
  input  fetch_pkg::instr_req_t req_i,
  output fetch_pkg::instr_rsp_t rsp_o
);
  import fetch_pkg::*;

  instr_t image [1024];  // Program image, wraps every 4 KiB

  logic  busy_q;   // Read granted, data not yet returned
  int    cnt_q;    // Cycles left until rvalid
  int    wait_q;   // Grant delay for the next request
  addr_t addr_q;

  // Low bits pick the length, about half of all halfwords start a full instr
  function automatic half_t rand_half();
    half_t h;
    h = half_t'($urandom);
    if ($urandom % 2 == 0) begin
      h[1:0] = 2'b11;
    end else begin
      h[1:0] = 2'($urandom % 3);  // Compressed quadrants 0 to 2
    end
    return h;
  endfunction

  task automatic fill_image();
    for (int i = 0; i < 1024; i++) begin
      image[i] = {rand_half(), rand_half()};
    end
  endtask

  always @(posedge clk or negedge rst_n) begin : respond
    int   lat;
    int   w;
    logic busy_n;
    if (!rst_n) begin
      rsp_o  <= '0;
      busy_q <= 1'b0;
      cnt_q  <= 0;
      wait_q <= 0;
      addr_q <= '0;
    end else begin
      busy_n = busy_q;
      w      = wait_q;
      rsp_o.rvalid <= 1'b0;
      if (busy_q) begin
        if (cnt_q == 1) begin
          rsp_o.rvalid <= 1'b1;
          rsp_o.rdata  <= image[addr_q[11:2]];
          busy_n = 1'b0;
        end else begin
          cnt_q <= cnt_q - 1;
        end
      end
      if (req_i.req && rsp_o.gnt) begin
        lat = 1 + $urandom % 4;  // rvalid 1 to 4 cycles after the grant
        w   = $urandom % 4;      // Grant delay 0 to 3 for the next request
        if (lat == 1) begin
          rsp_o.rvalid <= 1'b1;
          rsp_o.rdata  <= image[req_i.addr[11:2]];
        end else begin
          busy_n = 1'b1;
          cnt_q  <= lat - 1;
          addr_q <= req_i.addr;
        end
      end else if (req_i.req && !busy_q && w > 0) begin
        w = w - 1;  // Request waiting for its grant
      end
      busy_q    <= busy_n;
      wait_q    <= w;
      rsp_o.gnt <= !busy_n && (w == 0);  // Grant may sit high before req rises
    end
  end

endmodule

//--- dv/fetch_tb_checker.sv
`timescale 1ns/1ps

// Reference pc walk over the memory image, compared on every accepted instr
module fetch_tb_checker #(
  parameter fetch_pkg::addr_t BOOT_ADDR = '0
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  branch_i,
  input  fetch_pkg::addr_t      branch_addr_i,
  input  logic                  id_ready_i,
  input  logic                  id_valid_i,
  input  fetch_pkg::fetch_out_t id_data_i,
  input  fetch_pkg::instr_req_t instr_req_i
);
  import fetch_pkg::*;

  int         mismatches;
  int         protocol_errors;
  int         transfers;
  int         misal_full;          // Full instrs that start in an upper half
  int         after_rst;           // Cycles since reset release
  int         idle_cycles;         // Cycles since the last transfer
  logic       rst_seen = 1'b0;
  logic       hold_q;              // Valid instr stalled by decode last cycle
  fetch_out_t held_q;
  addr_t      ref_pc;

  function automatic half_t half_at(addr_t a);
    instr_t w;
    w = fetch_tb.mem_i.image[a[11:2]];  // Same 4 KiB wrap as the memory
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  task automatic report_value(string name, logic [31:0] got, logic [31:0] exp);
    mismatches++;
    $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
  endtask

  task automatic protocol_error(string what);
    protocol_errors++;
    $display("ERROR at %0t ns: %s", $time, what);
  endtask

  task automatic check_transfer();
    half_t  lo;
    logic   comp;
    instr_t exp;
    lo   = half_at(ref_pc);
    comp = (lo[1:0] != 2'b11);
    // Full instr takes its high half from the next halfword, maybe next word
    exp  = comp ? {16'h0000, lo} : {half_at(ref_pc + 32'd2), lo};
    transfers++;
    if (!comp && ref_pc[1]) begin
      misal_full++;
    end
    if (id_data_i.pc !== ref_pc) report_value("id_data_o.pc", id_data_i.pc, ref_pc);
    if (id_data_i.instr !== exp) report_value("id_data_o.instr", id_data_i.instr, exp);
    if (id_data_i.compressed !== comp) begin
      report_value("id_data_o.compressed", {31'd0, id_data_i.compressed}, {31'd0, comp});
    end
    ref_pc = ref_pc + (comp ? 32'd2 : 32'd4);
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      if (rst_seen && (id_valid_i || instr_req_i.req)) begin
        protocol_error("id_valid_o or instr_req_o.req high during reset");
      end
      rst_seen    = 1'b1;
      ref_pc      = BOOT_ADDR;
      after_rst   = 0;
      idle_cycles = 0;
      hold_q      = 1'b0;
    end else begin
      after_rst++;
      if (after_rst == 1 && (id_valid_i || instr_req_i.req)) begin
        protocol_error("fetch activity in the first cycle after reset");
      end
      if (after_rst == 2) begin  // Boot fetch one cycle after reset ends
        if (!instr_req_i.req) begin
          protocol_error("no fetch request one cycle after reset");
        end else if (instr_req_i.addr != {BOOT_ADDR[31:2], 2'b00}) begin
          report_value("instr_req_o.addr", instr_req_i.addr, {BOOT_ADDR[31:2], 2'b00});
        end
      end
      if (hold_q) begin
        if (!id_valid_i) begin
          protocol_error("id_valid_o dropped while decode was stalling");
        end else begin
          if (id_data_i.instr !== held_q.instr) begin
            report_value("id_data_o.instr (stalled)", id_data_i.instr, held_q.instr);
          end
          if (id_data_i.pc !== held_q.pc) begin
            report_value("id_data_o.pc (stalled)", id_data_i.pc, held_q.pc);
          end
          if (id_data_i.compressed !== held_q.compressed) begin
            report_value("id_data_o.compressed (stalled)", {31'd0, id_data_i.compressed},
                         {31'd0, held_q.compressed});
          end
        end
      end
      if (id_valid_i && id_ready_i) begin
        check_transfer();  // Transfer in a branch cycle still belongs to the old path
        idle_cycles = 0;
      end else begin
        idle_cycles++;
      end
      if (idle_cycles > 200) begin
        protocol_error("no instruction reached decode within 200 cycles");
        idle_cycles = 0;
      end
      hold_q = id_valid_i && !id_ready_i && !branch_i;  // Flush ends a stall
      held_q = id_data_i;
      if (branch_i) begin
        ref_pc = branch_addr_i;
      end
    end
  end

endmodule

//--- dv/fetch_tb.sv
`timescale 1ns/1ps

// Testbench for the fetch front end with random branches and decode stalls
module fetch_tb;
  import fetch_pkg::*;

  localparam addr_t BOOT_ADDR  = 32'h0000_0080;
  localparam int    RUN_CYCLES = 6000;

  logic       clk;
  logic       rst_n;
  logic       branch;
  addr_t      branch_addr;
  logic       id_ready;
  logic       id_valid;
  fetch_out_t id_data;
  instr_req_t instr_req;
  instr_rsp_t instr_rsp;
  logic       branch_on;    // Branches only once the boot fetch is through
  int         run_errors;

  always #2 clk = ~clk;  // 4 ns period

  fetch_top #(
    .BOOT_ADDR (BOOT_ADDR)
  ) dut_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .id_ready_i    (id_ready),
    .id_valid_o    (id_valid),
    .id_data_o     (id_data),
    .instr_req_o   (instr_req),
    .instr_rsp_i   (instr_rsp)
  );

  fetch_tb_mem mem_i (.clk(clk), .rst_n(rst_n), .req_i(instr_req), .rsp_o(instr_rsp));

  fetch_tb_checker #(
    .BOOT_ADDR (BOOT_ADDR)
  ) chk_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch),
    .branch_addr_i (branch_addr),
    .id_ready_i    (id_ready),
    .id_valid_i    (id_valid),
    .id_data_i     (id_data),
    .instr_req_i   (instr_req)
  );

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      id_ready <= ($urandom % 10) < 7;  // About 70 % ready
      if (branch_on && ($urandom % 40) == 0) begin
        branch      <= 1'b1;
        branch_addr <= ($urandom % 32'd4096) & 32'hffff_fffe;  // Even, inside image
      end else begin
        branch <= 1'b0;
      end
    end
  end

  task automatic wait_first_transfer(output logic ok);
    ok = 1'b0;
    for (int i = 0; i < 200 && !ok; i++) begin
      @(negedge clk);
      ok = (chk_i.transfers > 0);
    end
    if (!ok) begin
      run_errors++;
      $display("ERROR: no instruction delivered within 200 cycles after reset");
    end
  endtask

  task automatic finish_run();
    int total;
    if (chk_i.misal_full == 0 || chk_i.transfers < 100) begin
      run_errors++;
      $display("ERROR: too few transfers or no misaligned full instruction seen");
    end
    total = chk_i.mismatches + chk_i.protocol_errors + run_errors;
    $display("Transfers %0d, misaligned %0d, errors: value %0d, protocol %0d, run %0d",
             chk_i.transfers, chk_i.misal_full, chk_i.mismatches, chk_i.protocol_errors,
             run_errors);
    if (total == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  initial begin : main
    logic ok;
    void'($urandom(10327));
    clk         = 1'b0;
    rst_n       = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    id_ready    = 1'b0;
    branch_on   = 1'b0;
    run_errors  = 0;
    mem_i.fill_image();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    wait_first_transfer(ok);
    if (ok) begin
      branch_on = 1'b1;
      repeat (RUN_CYCLES) @(negedge clk);
      branch_on = 1'b0;
    end
    finish_run();
  end

endmodule

//--- list.f
source/fetch_pkg.sv
source/fetch_prefetch_buffer.sv
source/fetch_if_stage.sv
source/fetch_top.sv
dv/fetch_tb_mem.sv
dv/fetch_tb_checker.sv
dv/fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the fetch front end with Verilator and run its testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module fetch_tb -f list.f -o fetch_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  tail -n 20 sim.log
  echo "Simulation exited with status $status"
  exit 1
fi

tail -n 3 sim.log
if grep -qx "=== PASS ===" sim.log; then
  exit 0
fi
echo "Pass line not found in sim.log"
exit 1
